//--- rename_stage.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/rename_freelist.sv
hdl/rename_map.sv
hdl/rename_bypass.sv
hdl/rename_stage.sv
dv/rename_assert.sv
dv/rename_tb.sv

//--- run.sh
#!/bin/sh
# build the rename stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rename_tb \
  -f rename_stage.f -o rename_sim \
  && out="$(./obj_dir/rename_sim)" \
  ; echo "$out" \
  && echo "$out" | grep -q "TEST PASSED" \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation failed"; exit 1; }

//--- dv/rename_tb.sv
`timescale 1ns/10ps

`include "rename_defines.svh"

module rename_tb
  import rename_pkg::*;
();

  logic       i_clk;
  logic       i_reset_n;
  logic       i_disp_valid;
  logic       o_disp_ready;
  slot_mask_t i_inst_valid;
  slot_mask_t i_rd_valid;
  arch_reg_t  i_rd_regidx [`DISP_SIZE];
  arch_reg_t  i_rs1_regidx [`DISP_SIZE];
  arch_reg_t  i_rs2_regidx [`DISP_SIZE];
  logic       i_commit_valid;
  slot_mask_t i_cmt_rd_valid;
  arch_reg_t  i_cmt_rd_regidx [`DISP_SIZE];
  rnid_t      i_cmt_rd_rnid [`DISP_SIZE];
  rnid_t      i_cmt_old_rnid [`DISP_SIZE];
  slot_mask_t i_cmt_dead;
  logic       o_rn_valid;
  slot_mask_t o_rn_inst_valid;
  rnid_t      o_rn_rd_rnid [`DISP_SIZE];
  rnid_t      o_rn_old_rnid [`DISP_SIZE];
  rnid_t      o_rn_rs1_rnid [`DISP_SIZE];
  rnid_t      o_rn_rs2_rnid [`DISP_SIZE];

  // reference state
  rnid_t fl0_q [$];
  rnid_t fl1_q [$];
  rnid_t map_m [`ARCH_REGS];
  rnid_t last_rd [`DISP_SIZE];
  rnid_t last_old [`DISP_SIZE];
  rnid_t hist_new [`FLIST_SIZE]; // per fire of the exhaustion test
  rnid_t hist_old [`FLIST_SIZE];

  rename_stage rename_stage_i (.*);

  always #5 i_clk = ~i_clk;

  initial begin
    #50000;
    $display("simulation ran too long, stopping");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic check(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("** Error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic rnid_t model_pop(int d);
    if (d == 0)
      return fl0_q.pop_front();
    return fl1_q.pop_front();
  endfunction

  function automatic void model_push(int d, rnid_t id);
    if (d == 0)
      fl0_q.push_back(id);
    else
      fl1_q.push_back(id);
  endfunction

  task automatic reset_dut();
    i_reset_n      = 1'b0;
    i_disp_valid   = 1'b0;
    i_inst_valid   = '0;
    i_rd_valid     = '0;
    i_commit_valid = 1'b0;
    i_cmt_rd_valid = '0;
    i_cmt_dead     = '0;
    for (int d = 0; d < `DISP_SIZE; d++) begin
      i_rd_regidx[d]     = '0;
      i_rs1_regidx[d]    = '0;
      i_rs2_regidx[d]    = '0;
      i_cmt_rd_regidx[d] = '0;
      i_cmt_rd_rnid[d]   = '0;
      i_cmt_old_rnid[d]  = '0;
    end
    fl0_q.delete();
    fl1_q.delete();
    for (int i = 0; i < `FLIST_SIZE; i++) begin
      fl0_q.push_back(rnid_t'(`ARCH_REGS + i));
      fl1_q.push_back(rnid_t'(`ARCH_REGS + `FLIST_SIZE + i));
    end
    for (int i = 0; i < `ARCH_REGS; i++)
      map_m[i] = rnid_t'(i); // identity
    repeat (3) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    check("o_rn_valid", 0, int'(o_rn_valid));
    check("o_disp_ready", 1, int'(o_disp_ready));
  endtask

  task automatic set_group(input int iv, input int rdv,
                           input int rd0, input int rs10, input int rs20,
                           input int rd1, input int rs11, input int rs21);
    i_inst_valid    = slot_mask_t'(iv);
    i_rd_valid      = slot_mask_t'(rdv);
    i_rd_regidx[0]  = arch_reg_t'(rd0);
    i_rs1_regidx[0] = arch_reg_t'(rs10);
    i_rs2_regidx[0] = arch_reg_t'(rs20);
    i_rd_regidx[1]  = arch_reg_t'(rd1);
    i_rs1_regidx[1] = arch_reg_t'(rs11);
    i_rs2_regidx[1] = arch_reg_t'(rs21);
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!o_disp_ready) begin
      @(posedge i_clk);
      #1;
      n++;
      if (n > 20) begin
        $display("o_disp_ready stayed low after a commit");
        $display("TEST FAILED");
        $fatal(1, "ready timeout");
      end
    end
  endtask

  // slots renamed in program order against a working copy of the map
  task automatic fire_group();
    rnid_t loc [`ARCH_REGS];
    rnid_t e_rs1 [`DISP_SIZE];
    rnid_t e_rs2 [`DISP_SIZE];
    rnid_t e_old [`DISP_SIZE];
    rnid_t e_rd [`DISP_SIZE];
    wait_ready();
    loc = map_m;
    for (int d = 0; d < `DISP_SIZE; d++) begin
      e_rs1[d] = loc[i_rs1_regidx[d]];
      e_rs2[d] = loc[i_rs2_regidx[d]];
      e_old[d] = loc[i_rd_regidx[d]];
      e_rd[d]  = '0;
      if (i_inst_valid[d] && i_rd_valid[d] && i_rd_regidx[d] != '0) begin
        e_rd[d] = model_pop(d);
        loc[i_rd_regidx[d]] = e_rd[d];
      end
    end
    map_m    = loc;
    last_rd  = e_rd;
    last_old = e_old;
    i_disp_valid = 1'b1;
    @(posedge i_clk);
    #1;
    i_disp_valid = 1'b0;
    check("o_rn_valid", 1, int'(o_rn_valid));
    check("o_rn_inst_valid", int'(i_inst_valid), int'(o_rn_inst_valid));
    for (int d = 0; d < `DISP_SIZE; d++) begin
      if (i_inst_valid[d]) begin
        check($sformatf("o_rn_rs1_rnid[%0d]", d), int'(e_rs1[d]), int'(o_rn_rs1_rnid[d]));
        check($sformatf("o_rn_rs2_rnid[%0d]", d), int'(e_rs2[d]), int'(o_rn_rs2_rnid[d]));
        if (i_rd_valid[d]) begin
          check($sformatf("o_rn_rd_rnid[%0d]", d), int'(e_rd[d]), int'(o_rn_rd_rnid[d]));
          check($sformatf("o_rn_old_rnid[%0d]", d), int'(e_old[d]), int'(o_rn_old_rnid[d]));
        end
      end
    end
  endtask

  task automatic commit_slot(input int d, input int rd, input rnid_t new_id,
                             input rnid_t old_id, input logic dead);
    i_commit_valid     = 1'b1;
    i_cmt_rd_valid     = slot_mask_t'(1 << d);
    i_cmt_dead         = dead ? slot_mask_t'(1 << d) : '0;
    i_cmt_rd_regidx[d] = arch_reg_t'(rd);
    i_cmt_rd_rnid[d]   = new_id;
    i_cmt_old_rnid[d]  = old_id;
    if (rd != 0)
      model_push(d, dead ? new_id : old_id);
    @(posedge i_clk);
    #1;
    i_commit_valid = 1'b0;
    i_cmt_rd_valid = '0;
    @(posedge i_clk); // push lands here
    #1;
  endtask

  task automatic test_basic();
    set_group(3, 3, 3, 5, 7, 4, 7, 5);
    fire_group();
  endtask

  task automatic test_dependency();
    set_group(3, 3, 10, 1, 2, 10, 10, 10); // slot 1 reads and rewrites x10
    fire_group();
    set_group(2, 1, 10, 0, 0, 0, 10, 10); // slot 0 idle though its rd is flagged
    fire_group();
  endtask

  task automatic test_x0();
    set_group(3, 3, 0, 4, 5, 12, 0, 0);
    fire_group();
    set_group(1, 1, 11, 0, 3, 0, 0, 0);
    fire_group();
  endtask

  task automatic test_exhaust();
    reset_dut();
    for (int i = 0; i < `FLIST_SIZE; i++) begin
      set_group(1, 1, i + 1, 0, 0, 0, 0, 0);
      fire_group();
      hist_new[i] = last_rd[0];
      hist_old[i] = last_old[0];
    end
    check("o_disp_ready", 0, int'(o_disp_ready));
    set_group(1, 1, 20, 1, 2, 0, 0, 0);
    i_disp_valid = 1'b1; // held against back-pressure
    repeat (3) begin
      @(posedge i_clk);
      #1;
      check("o_rn_valid", 0, int'(o_rn_valid));
    end
    i_disp_valid = 1'b0;
    commit_slot(0, 1, hist_new[0], hist_old[0], 1'b0);
    wait_ready();
    fire_group();
  endtask

  task automatic test_dead();
    commit_slot(0, 2, hist_new[1], hist_old[1], 1'b1);
    commit_slot(0, 3, hist_new[2], hist_old[2], 1'b0);
    set_group(1, 1, 21, 2, 3, 0, 0, 0);
    fire_group();
    set_group(1, 1, 22, 21, 0, 0, 0, 0);
    fire_group();
  endtask

  initial begin
    i_clk = 1'b0;
    reset_dut();
    test_basic();
    test_dependency();
    test_x0();
    test_exhaust();
    test_dead();
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- dv/rename_assert.sv
`timescale 1ns/10ps

`include "rename_defines.svh"

module rename_assert
  import rename_pkg::*;
(
  input logic       i_clk,
  input logic       i_reset_n,
  input logic       i_disp_valid,
  input logic       i_disp_ready,
  input logic       i_rn_valid,
  input slot_mask_t i_alloc,
  input rnid_t      i_rd_rnid [`DISP_SIZE]
);

  logic w_fire;

  assign w_fire = i_disp_valid & i_disp_ready;

  a_reset_quiet: assert property (@(posedge i_clk) !i_reset_n |-> !i_rn_valid)
    else $error("o_rn_valid high in reset");

  // output valid is the fire delayed by one edge
  a_fire_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_fire |=> i_rn_valid) else $error("fire not followed by o_rn_valid");
  a_idle_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !w_fire |=> !i_rn_valid) else $error("o_rn_valid without a fire");

  for (genvar d = 0; d < `DISP_SIZE; d++) begin : g_slot
    a_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_alloc[d] |-> (i_rd_rnid[d] != '0)) else $error("renamed rd got register 0");
  end

endmodule

bind rename_stage rename_assert u_assert (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_disp_valid (i_disp_valid),
  .i_disp_ready (o_disp_ready),
  .i_rn_valid   (o_rn_valid),
  .i_alloc      (w_alloc),
  .i_rd_rnid    (w_rd_rnid)
);

//--- hdl/rename_stage.sv
`timescale 1ns/10ps

`include "rename_defines.svh"

module rename_stage
  import rename_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,

  // dispatch group in
  input  logic       i_disp_valid,
  output logic       o_disp_ready,
  input  slot_mask_t i_inst_valid,
  input  slot_mask_t i_rd_valid,
  input  arch_reg_t  i_rd_regidx [`DISP_SIZE],
  input  arch_reg_t  i_rs1_regidx [`DISP_SIZE],
  input  arch_reg_t  i_rs2_regidx [`DISP_SIZE],

  // commit
  input  logic       i_commit_valid,
  input  slot_mask_t i_cmt_rd_valid,
  input  arch_reg_t  i_cmt_rd_regidx [`DISP_SIZE],
  input  rnid_t      i_cmt_rd_rnid [`DISP_SIZE],
  input  rnid_t      i_cmt_old_rnid [`DISP_SIZE],
  input  slot_mask_t i_cmt_dead,

  // renamed group out
  output logic       o_rn_valid,
  output slot_mask_t o_rn_inst_valid,
  output rnid_t      o_rn_rd_rnid [`DISP_SIZE],
  output rnid_t      o_rn_old_rnid [`DISP_SIZE],
  output rnid_t      o_rn_rs1_rnid [`DISP_SIZE],
  output rnid_t      o_rn_rs2_rnid [`DISP_SIZE]
);

  logic       w_fire;
  slot_mask_t w_empty;
  slot_mask_t w_alloc; // slot pops and updates the map
  rnid_t      w_pop_id [`DISP_SIZE];
  rnid_t      w_rd_rnid [`DISP_SIZE];
  arch_reg_t  w_rs_regidx [`DISP_SIZE*2];
  rnid_t      w_map_rs_rnid [`DISP_SIZE*2];
  rnid_t      w_map_rs1_rnid [`DISP_SIZE];
  rnid_t      w_map_rs2_rnid [`DISP_SIZE];
  rnid_t      w_map_old_rnid [`DISP_SIZE];
  rnid_t      w_rs1_rnid [`DISP_SIZE];
  rnid_t      w_rs2_rnid [`DISP_SIZE];
  rnid_t      w_old_rnid [`DISP_SIZE];

  logic       r_cmt_valid;
  slot_mask_t r_cmt_rd_valid;
  slot_mask_t r_cmt_dead;
  arch_reg_t  r_cmt_rd_regidx [`DISP_SIZE];
  rnid_t      r_cmt_rd_rnid [`DISP_SIZE];
  rnid_t      r_cmt_old_rnid [`DISP_SIZE];

  assign o_disp_ready = ~(|w_empty); // every slot must be able to pop
  assign w_fire       = i_disp_valid & o_disp_ready;

  for (genvar d = 0; d < `DISP_SIZE; d++) begin : g_slot
    logic  w_push;
    rnid_t w_push_id;

    assign w_alloc[d] = w_fire & i_inst_valid[d] & i_rd_valid[d] & (i_rd_regidx[d] != '0);
    assign w_rd_rnid[d] = (i_rd_regidx[d] == '0) ? '0 : w_pop_id[d]; // x0 stays physical 0

    // dead instruction never became architectural, give back its own register
    assign w_push    = r_cmt_valid & r_cmt_rd_valid[d] & (r_cmt_rd_regidx[d] != '0);
    assign w_push_id = r_cmt_dead[d] ? r_cmt_rd_rnid[d] : r_cmt_old_rnid[d];

    rename_freelist #(
      .INIT (`ARCH_REGS + `FLIST_SIZE * d)
    ) u_freelist (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_push    (w_push),
      .i_push_id (w_push_id),
      .i_pop     (w_alloc[d]),
      .o_pop_id  (w_pop_id[d]),
      .o_empty   (w_empty[d])
    );

    assign w_rs_regidx[d*2]   = i_rs1_regidx[d];
    assign w_rs_regidx[d*2+1] = i_rs2_regidx[d];
    assign w_map_rs1_rnid[d]  = w_map_rs_rnid[d*2];
    assign w_map_rs2_rnid[d]  = w_map_rs_rnid[d*2+1];
  end

  rename_map u_map (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_rs_regidx   (w_rs_regidx),
    .o_rs_rnid     (w_map_rs_rnid),
    .i_rd_regidx   (i_rd_regidx),
    .o_rd_old_rnid (w_map_old_rnid),
    .i_update      (w_alloc),
    .i_update_rnid (w_rd_rnid)
  );

  rename_bypass u_bypass (
    .i_inst_valid   (i_inst_valid),
    .i_rd_valid     (i_rd_valid),
    .i_rd_regidx    (i_rd_regidx),
    .i_rs1_regidx   (i_rs1_regidx),
    .i_rs2_regidx   (i_rs2_regidx),
    .i_rd_rnid      (w_rd_rnid),
    .i_map_rs1_rnid (w_map_rs1_rnid),
    .i_map_rs2_rnid (w_map_rs2_rnid),
    .i_map_old_rnid (w_map_old_rnid),
    .o_rs1_rnid     (w_rs1_rnid),
    .o_rs2_rnid     (w_rs2_rnid),
    .o_old_rnid     (w_old_rnid)
  );

  // commit is pushed one cycle late
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cmt_valid    <= 1'b0;
      r_cmt_rd_valid <= '0;
    end else begin
      r_cmt_valid    <= i_commit_valid;
      r_cmt_rd_valid <= i_cmt_rd_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_cmt_dead      <= i_cmt_dead;
    r_cmt_rd_regidx <= i_cmt_rd_regidx;
    r_cmt_rd_rnid   <= i_cmt_rd_rnid;
    r_cmt_old_rnid  <= i_cmt_old_rnid;
  end

  // output stage
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_rn_valid      <= 1'b0;
      o_rn_inst_valid <= '0;
    end else begin
      o_rn_valid      <= w_fire;
      o_rn_inst_valid <= w_fire ? i_inst_valid : '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fire) begin
      o_rn_rd_rnid  <= w_rd_rnid;
      o_rn_old_rnid <= w_old_rnid;
      o_rn_rs1_rnid <= w_rs1_rnid;
      o_rn_rs2_rnid <= w_rs2_rnid;
    end
  end

endmodule

//--- hdl/rename_bypass.sv
`timescale 1ns/10ps

`include "rename_defines.svh"

module rename_bypass
  import rename_pkg::*;
(
  input  slot_mask_t i_inst_valid,
  input  slot_mask_t i_rd_valid,
  input  arch_reg_t  i_rd_regidx [`DISP_SIZE],
  input  arch_reg_t  i_rs1_regidx [`DISP_SIZE],
  input  arch_reg_t  i_rs2_regidx [`DISP_SIZE],
  input  rnid_t      i_rd_rnid [`DISP_SIZE],      // freshly allocated
  input  rnid_t      i_map_rs1_rnid [`DISP_SIZE],
  input  rnid_t      i_map_rs2_rnid [`DISP_SIZE],
  input  rnid_t      i_map_old_rnid [`DISP_SIZE],
  output rnid_t      o_rs1_rnid [`DISP_SIZE],
  output rnid_t      o_rs2_rnid [`DISP_SIZE],
  output rnid_t      o_old_rnid [`DISP_SIZE]
);

  slot_mask_t w_wr; // slot really writes a destination

  assign w_wr = i_inst_valid & i_rd_valid;

  // the map still holds the state from before this group, so any slot
  // that reads or overwrites a register written by an older slot in the
  // same group has to take that slot's new number instead
  always_comb begin
    for (int d = 0; d < `DISP_SIZE; d++) begin
      o_rs1_rnid[d] = i_map_rs1_rnid[d];
      o_rs2_rnid[d] = i_map_rs2_rnid[d];
      o_old_rnid[d] = i_map_old_rnid[d];

      // oldest first, a later match overrides so the nearest slot wins
      for (int p = 0; p < d; p++) begin
        if (w_wr[p] && (i_rd_regidx[p] == i_rs1_regidx[d])) begin
          o_rs1_rnid[d] = i_rd_rnid[p];
        end
        if (w_wr[p] && (i_rd_regidx[p] == i_rs2_regidx[d])) begin
          o_rs2_rnid[d] = i_rd_rnid[p];
        end
        if (w_wr[p] && (i_rd_regidx[p] == i_rd_regidx[d])) begin
          o_old_rnid[d] = i_rd_rnid[p]; // WAW inside the group
        end
      end
    end
  end

endmodule

//--- hdl/rename_map.sv
`timescale 1ns/10ps

`include "rename_defines.svh"

module rename_map
  import rename_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,

  // sources, slot d uses entries 2d (rs1) and 2d+1 (rs2)
  input  arch_reg_t  i_rs_regidx [`DISP_SIZE*2],
  output rnid_t      o_rs_rnid [`DISP_SIZE*2],

  // previous mapping of each destination
  input  arch_reg_t  i_rd_regidx [`DISP_SIZE],
  output rnid_t      o_rd_old_rnid [`DISP_SIZE],

  // group update, written at the same index as i_rd_regidx
  input  slot_mask_t i_update,
  input  rnid_t      i_update_rnid [`DISP_SIZE]
);

  rnid_t r_map [`ARCH_REGS];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `ARCH_REGS; i++) begin
        r_map[i] <= rnid_t'(i); // identity
      end
    end else begin
      // ascending order so the youngest writer of a register wins
      for (int d = 0; d < `DISP_SIZE; d++) begin
        if (i_update[d]) begin
          r_map[i_rd_regidx[d]] <= i_update_rnid[d];
        end
      end
    end
  end

  always_comb begin
    for (int s = 0; s < `DISP_SIZE*2; s++) begin
      o_rs_rnid[s] = r_map[i_rs_regidx[s]];
    end
  end

  always_comb begin
    for (int d = 0; d < `DISP_SIZE; d++) begin
      o_rd_old_rnid[d] = r_map[i_rd_regidx[d]];
    end
  end

endmodule

//--- hdl/rename_freelist.sv
`timescale 1ns/10ps

`include "rename_defines.svh"

module rename_freelist
  import rename_pkg::*;
#(
  parameter int INIT = 32 // first physical number owned by this list
) (
  input  logic  i_clk,
  input  logic  i_reset_n,
  input  logic  i_push,
  input  rnid_t i_push_id,
  input  logic  i_pop,
  output rnid_t o_pop_id,
  output logic  o_empty
);

  localparam int PTR_W = $clog2(`FLIST_SIZE);

  rnid_t            r_list [`FLIST_SIZE];
  logic [PTR_W-1:0] r_head;
  logic [PTR_W-1:0] r_tail;
  logic [PTR_W:0]   r_count; // one extra bit so full fits

  // pointers wrap naturally since FLIST_SIZE is a power of two
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head  <= '0;
      r_tail  <= '0;  // full, so tail meets head
      r_count <= (PTR_W+1)'(`FLIST_SIZE);
    end else begin
      if (i_pop) r_head <= r_head + 1'b1;
      if (i_push) r_tail <= r_tail + 1'b1;
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count; // both or neither
      endcase
    end
  end

  // storage comes up holding INIT upward
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < `FLIST_SIZE; i++) begin
        r_list[i] <= rnid_t'(INIT + i);
      end
    end else if (i_push) begin
      r_list[r_tail] <= i_push_id;
    end
  end

  assign o_pop_id = r_list[r_head]; // head is visible before the pop
  assign o_empty  = (r_count == '0);

endmodule

//--- hdl/rename_pkg.sv
package rename_pkg;

`include "rename_defines.svh"

  // architectural register index
  typedef logic [`ARCH_W-1:0] arch_reg_t;

  // physical register number
  typedef logic [`RNID_W-1:0] rnid_t;

  // one bit per dispatch slot
  typedef logic [`DISP_SIZE-1:0] slot_mask_t;

endpackage

//--- hdl/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// dispatch group width
`define DISP_SIZE 2

// integer architectural registers, x0 included
`define ARCH_REGS 32
`define ARCH_W 5

// entries in each per-slot free list, keep a power of two
`define FLIST_SIZE 16

// physical register number width
// covers ARCH_REGS + DISP_SIZE * FLIST_SIZE = 64 registers
`define RNID_W 6

`endif
